// File: logic/axi_pkg.sv
`include "bus_cfg.svh"

package axi_pkg;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } axi_burst_e;

    // AR and AW share one layout
    typedef struct packed {
        logic [`BUS_ID_W-1:0]   id;
        logic [`BUS_ADDR_W-1:0] addr;
        logic [7:0]             len;   // Beats minus one
        logic [2:0]             size;  // Log2 of bytes per beat
        axi_burst_e             burst;
    } axi_ax_t;

    typedef struct packed {
        logic [`BUS_DATA_W-1:0]   data;
        logic [`BUS_DATA_W/8-1:0] strb;
        logic                     last;
    } axi_w_t;

    typedef struct packed {
        logic [`BUS_ID_W-1:0] id;
        axi_resp_e            resp;
    } axi_b_t;

    typedef struct packed {
        logic [`BUS_ID_W-1:0]   id;
        logic [`BUS_DATA_W-1:0] data;
        axi_resp_e              resp;
        logic                   last;
    } axi_r_t;

endpackage

// File: logic/axi_rw_bridge.sv
module axi_rw_bridge
    import axi_pkg::*, mem_req_pkg::*;
(
    input  logic     clock,
    input  logic     rst_n_i,
    input  logic     req_i,
    input  mem_req_t req_data_i,
    input  master_e  master_i,
    output logic     done_o,
    output mem_rsp_t rsp_o,
    output logic     ar_valid_o,
    output axi_ax_t  ar_o,
    input  logic     ar_ready_i,
    input  logic     r_valid_i,
    input  axi_r_t   r_i,
    output logic     r_ready_o,
    output logic     aw_valid_o,
    output axi_ax_t  aw_o,
    input  logic     aw_ready_i,
    output logic     w_valid_o,
    output axi_w_t   w_o,
    input  logic     w_ready_i,
    input  logic     b_valid_i,
    input  axi_b_t   b_i,
    output logic     b_ready_o
);

    typedef enum logic [2:0] {
        IDLE,
        RD_ADDR,
        RD_DATA,
        WR_REQ,
        WR_RESP,
        DONE
    } state_e;

    state_e   state;
    logic     aw_done_q;    // AW already taken
    logic     w_done_q;     // W already taken
    logic     aw_hs;
    logic     w_hs;
    mem_req_t req_q;
    master_e  master_q;
    mem_rsp_t rsp_q;
    axi_ax_t  ax;

    assign aw_hs = aw_valid_o && aw_ready_i;
    assign w_hs  = w_valid_o && w_ready_i;

    always_ff @(posedge clock or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state     <= IDLE;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (req_i) begin
                        state <= (req_data_i.op == OP_WRITE) ? WR_REQ : RD_ADDR;
                    end
                end
                RD_ADDR: begin
                    if (ar_ready_i) begin
                        state <= RD_DATA;
                    end
                end
                RD_DATA: begin
                    if (r_valid_i) begin
                        state <= DONE;
                    end
                end
                WR_REQ: begin
                    // Either channel may go first
                    if ((aw_done_q || aw_hs) && (w_done_q || w_hs)) begin
                        state     <= WR_RESP;
                        aw_done_q <= 1'b0;
                        w_done_q  <= 1'b0;
                    end else begin
                        aw_done_q <= aw_done_q || aw_hs;
                        w_done_q  <= w_done_q || w_hs;
                    end
                end
                WR_RESP: begin
                    if (b_valid_i) begin
                        state <= DONE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == IDLE && req_i) begin
            req_q    <= req_data_i;
            master_q <= master_i;
        end
        if (state == RD_DATA && r_valid_i) begin
            rsp_q <= '{rdata: r_i.data, resp: r_i.resp};
        end
        if (state == WR_RESP && b_valid_i) begin
            rsp_q <= '{rdata: '0, resp: b_i.resp};
        end
    end

    // Single beat, INCR, ID is the master
    assign ax = '{id: master_q, addr: req_q.addr, len: 8'd0,
                  size: {1'b0, req_q.size}, burst: INCR};

    assign ar_o       = ax;
    assign aw_o       = ax;
    assign w_o        = '{data: req_q.wdata, strb: req_q.wstrb, last: 1'b1};
    assign ar_valid_o = state == RD_ADDR;
    assign r_ready_o  = state == RD_DATA;
    assign aw_valid_o = state == WR_REQ && !aw_done_q;
    assign w_valid_o  = state == WR_REQ && !w_done_q;
    assign b_ready_o  = state == WR_RESP;
    assign done_o     = state == DONE;
    assign rsp_o      = rsp_q;

    a_ar_stable: assert property (@(posedge clock) disable iff (!rst_n_i)
        ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o));

    a_aw_stable: assert property (@(posedge clock) disable iff (!rst_n_i)
        aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_o));

    // Slave must answer with the ID it was given
    a_r_id: assert property (@(posedge clock) disable iff (!rst_n_i)
        r_valid_i && r_ready_o |-> r_i.id == master_q);

    a_b_id: assert property (@(posedge clock) disable iff (!rst_n_i)
        b_valid_i && b_ready_o |-> b_i.id == master_q);

endmodule

// File: logic/bus_cfg.svh
`ifndef BUS_CFG_SVH
`define BUS_CFG_SVH

// Shared bus geometry
`define BUS_ADDR_W  32
`define BUS_DATA_W  64
`define BUS_ID_W    4

// Memory model depth in 64-bit words, beyond it SLVERR
`define MEM_WORDS   1024

`endif

// File: logic/ifu_port.sv
`include "bus_cfg.svh"

module ifu_port
    import axi_pkg::*, mem_req_pkg::*;
(
    input  logic                   clock,
    input  logic                   rst_n_i,
    input  logic                   fetch_req_i,
    input  logic [`BUS_ADDR_W-1:0] fetch_addr_i,
    output logic                   fetch_done_o,
    output logic [31:0]            fetch_instr_o,
    output axi_resp_e              fetch_resp_o,
    output logic                   req_o,
    output mem_req_t               req_o_data,
    input  logic                   done_i,
    input  mem_rsp_t               rsp_i
);

    assign req_o = fetch_req_i;

    always_comb begin
        req_o_data       = '0;
        req_o_data.op    = OP_READ;
        req_o_data.addr  = {fetch_addr_i[`BUS_ADDR_W-1:2], 2'b00};
        req_o_data.size  = SZ_WORD;
    end

    assign fetch_done_o  = done_i;
    assign fetch_resp_o  = rsp_i.resp;
    // Address held until done, so bit 2 still picks the half
    assign fetch_instr_o = fetch_addr_i[2] ? rsp_i.rdata[63:32] : rsp_i.rdata[31:0];

    // Fetch address stays put and aligned while waiting
    a_fetch_aligned: assert property (@(posedge clock) disable iff (!rst_n_i)
        fetch_req_i |-> fetch_addr_i[1:0] == 2'b00);

    a_fetch_hold: assert property (@(posedge clock) disable iff (!rst_n_i)
        fetch_req_i && !done_i |=> fetch_req_i && $stable(fetch_addr_i));

endmodule

// File: logic/lsu_port.sv
`include "bus_cfg.svh"

module lsu_port
    import axi_pkg::*, mem_req_pkg::*;
(
    input  logic                   clock,
    input  logic                   rst_n_i,
    input  logic                   ls_req_i,
    input  mem_op_e                ls_op_i,
    input  logic [`BUS_ADDR_W-1:0] ls_addr_i,
    input  mem_size_e              ls_size_i,
    input  logic [`BUS_DATA_W-1:0] ls_wdata_i,
    output logic                   ls_done_o,
    output logic [`BUS_DATA_W-1:0] ls_rdata_o,
    output axi_resp_e              ls_resp_o,
    output logic                   req_o,
    output mem_req_t               req_o_data,
    input  logic                   done_i,
    input  mem_rsp_t               rsp_i
);

    localparam int DW = `BUS_DATA_W;
    localparam int SW = DW / 8;
    localparam int OW = $clog2(SW);

    logic [SW-1:0] base_strb;   // Unshifted byte enables
    logic [DW-1:0] data_mask;
    logic [OW-1:0] lane;
    logic [DW-1:0] load_shift;

    assign lane = ls_addr_i[OW-1:0];

    always_comb begin
        case (ls_size_i)
            SZ_BYTE: base_strb = SW'(8'h01);
            SZ_HALF: base_strb = SW'(8'h03);
            SZ_WORD: base_strb = SW'(8'h0f);
            default: base_strb = '1;
        endcase
        for (int i = 0; i < SW; i++) begin
            data_mask[8*i +: 8] = {8{base_strb[i]}};
        end
    end

    assign req_o = ls_req_i;

    always_comb begin
        req_o_data      = '0;
        req_o_data.op   = ls_op_i;
        req_o_data.addr = ls_addr_i;
        req_o_data.size = ls_size_i;
        if (ls_op_i == OP_WRITE) begin
            req_o_data.wstrb = base_strb << lane;
            req_o_data.wdata = (ls_wdata_i & data_mask) << {lane, 3'b000};
        end
    end

    // Load lane down to bit 0, zero-extend
    assign load_shift = rsp_i.rdata >> {lane, 3'b000};
    assign ls_rdata_o = load_shift & data_mask;
    assign ls_done_o  = done_i;
    assign ls_resp_o  = rsp_i.resp;

    // Natural alignment: low address bits under the size must be zero
    a_ls_aligned: assert property (@(posedge clock) disable iff (!rst_n_i)
        ls_req_i |-> (lane & ((OW'(1) << ls_size_i) - OW'(1))) == '0);

    a_ls_hold: assert property (@(posedge clock) disable iff (!rst_n_i)
        ls_req_i && !done_i |=> ls_req_i && $stable(req_o_data));

endmodule

// File: logic/mem_arbiter.sv
module mem_arbiter
    import mem_req_pkg::*;
(
    input  logic     clock,
    input  logic     rst_n_i,
    input  logic     ifu_req_i,
    input  mem_req_t ifu_data_i,
    input  logic     lsu_req_i,
    input  mem_req_t lsu_data_i,
    output logic     ifu_done_o,
    output logic     lsu_done_o,
    output logic     req_o,
    output mem_req_t req_data_o,
    output master_e  master_o,
    input  logic     done_i,
    input  mem_rsp_t rsp_i,
    output mem_rsp_t rsp_o
);

    logic    busy;
    master_e owner;
    master_e last_grant;
    master_e pick;

    // Both asking means the one not served last wins
    always_comb begin
        if (ifu_req_i && lsu_req_i) begin
            pick = (last_grant == MST_IFU) ? MST_LSU : MST_IFU;
        end else if (lsu_req_i) begin
            pick = MST_LSU;
        end else begin
            pick = MST_IFU;
        end
    end

    always_ff @(posedge clock or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy       <= 1'b0;
            owner      <= MST_IFU;
            last_grant <= MST_LSU;  // Fetch goes first after reset
        end else if (!busy) begin
            if (ifu_req_i || lsu_req_i) begin
                busy       <= 1'b1;
                owner      <= pick;
                last_grant <= pick;
            end
        end else if (done_i) begin
            busy <= 1'b0;
        end
    end

    assign req_o      = busy;
    assign master_o   = owner;
    assign req_data_o = (owner == MST_IFU) ? ifu_data_i : lsu_data_i;
    assign rsp_o      = rsp_i;
    assign ifu_done_o = done_i && owner == MST_IFU;
    assign lsu_done_o = done_i && owner == MST_LSU;

    // Bridge only finishes a granted transfer whose port is still waiting
    a_done_owned: assert property (@(posedge clock) disable iff (!rst_n_i)
        done_i |-> busy && ((owner == MST_IFU) ? ifu_req_i : lsu_req_i));

endmodule

// File: logic/mem_req_pkg.sv
`include "bus_cfg.svh"

package mem_req_pkg;

    import axi_pkg::*;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } mem_op_e;

    // Same code as AXI size
    typedef enum logic [1:0] {
        SZ_BYTE  = 2'b00,
        SZ_HALF  = 2'b01,
        SZ_WORD  = 2'b10,
        SZ_DWORD = 2'b11
    } mem_size_e;

    // Doubles as the AXI ID
    typedef enum logic [`BUS_ID_W-1:0] {
        MST_IFU = `BUS_ID_W'(0),
        MST_LSU = `BUS_ID_W'(1)
    } master_e;

    typedef struct packed {
        mem_op_e                  op;
        logic [`BUS_ADDR_W-1:0]   addr;
        mem_size_e                size;
        logic [`BUS_DATA_W-1:0]   wdata;  // Already in its byte lane
        logic [`BUS_DATA_W/8-1:0] wstrb;
    } mem_req_t;

    typedef struct packed {
        logic [`BUS_DATA_W-1:0] rdata;  // Raw beat
        axi_resp_e              resp;
    } mem_rsp_t;

endpackage

// File: logic/sim_top.sv
`include "bus_cfg.svh"

module sim_top
    import axi_pkg::*, mem_req_pkg::*;
(
    input  logic                   clock,
    input  logic                   rst_n_i,
    input  logic                   fetch_req_i,
    input  logic [`BUS_ADDR_W-1:0] fetch_addr_i,
    output logic                   fetch_done_o,
    output logic [31:0]            fetch_instr_o,
    output axi_resp_e              fetch_resp_o,
    input  logic                   ls_req_i,
    input  mem_op_e                ls_op_i,
    input  logic [`BUS_ADDR_W-1:0] ls_addr_i,
    input  mem_size_e              ls_size_i,
    input  logic [`BUS_DATA_W-1:0] ls_wdata_i,
    output logic                   ls_done_o,
    output logic [`BUS_DATA_W-1:0] ls_rdata_o,
    output axi_resp_e              ls_resp_o,
    output logic                   ar_valid_o,
    output axi_ax_t                ar_o,
    input  logic                   ar_ready_i,
    input  logic                   r_valid_i,
    input  axi_r_t                 r_i,
    output logic                   r_ready_o,
    output logic                   aw_valid_o,
    output axi_ax_t                aw_o,
    input  logic                   aw_ready_i,
    output logic                   w_valid_o,
    output axi_w_t                 w_o,
    input  logic                   w_ready_i,
    input  logic                   b_valid_i,
    input  axi_b_t                 b_i,
    output logic                   b_ready_o
);

    logic     ifu_req, ifu_done, lsu_req, lsu_done;
    mem_req_t ifu_req_data, lsu_req_data;
    mem_rsp_t port_rsp;                     // Arbiter to both ports
    logic     bus_req, bus_done;
    mem_req_t bus_req_data;
    master_e  bus_master;
    mem_rsp_t bus_rsp;

    ifu_port u_ifu (
        .clock, .rst_n_i, .fetch_req_i, .fetch_addr_i, .fetch_done_o,
        .fetch_instr_o, .fetch_resp_o,
        .req_o(ifu_req), .req_o_data(ifu_req_data), .done_i(ifu_done), .rsp_i(port_rsp)
    );

    lsu_port u_lsu (
        .clock, .rst_n_i, .ls_req_i, .ls_op_i, .ls_addr_i, .ls_size_i, .ls_wdata_i,
        .ls_done_o, .ls_rdata_o, .ls_resp_o,
        .req_o(lsu_req), .req_o_data(lsu_req_data), .done_i(lsu_done), .rsp_i(port_rsp)
    );

    mem_arbiter u_arb (
        .clock, .rst_n_i,
        .ifu_req_i(ifu_req), .ifu_data_i(ifu_req_data),
        .lsu_req_i(lsu_req), .lsu_data_i(lsu_req_data),
        .ifu_done_o(ifu_done), .lsu_done_o(lsu_done),
        .req_o(bus_req), .req_data_o(bus_req_data), .master_o(bus_master),
        .done_i(bus_done), .rsp_i(bus_rsp), .rsp_o(port_rsp)
    );

    axi_rw_bridge u_bridge (
        .clock, .rst_n_i,
        .req_i(bus_req), .req_data_i(bus_req_data), .master_i(bus_master),
        .done_o(bus_done), .rsp_o(bus_rsp),
        .ar_valid_o, .ar_o, .ar_ready_i, .r_valid_i, .r_i, .r_ready_o,
        .aw_valid_o, .aw_o, .aw_ready_i, .w_valid_o, .w_o, .w_ready_i,
        .b_valid_i, .b_i, .b_ready_o
    );

endmodule

// File: sim.f
+incdir+logic
logic/axi_pkg.sv
logic/mem_req_pkg.sv
logic/ifu_port.sv
logic/lsu_port.sv
logic/mem_arbiter.sv
logic/axi_rw_bridge.sv
logic/sim_top.sv
tb/axi_mem_model.sv
tb/tb_sim_top.sv

// File: tb/axi_mem_model.sv
`include "bus_cfg.svh"

module axi_mem_model
    import axi_pkg::*;
(
    input  logic    clock,
    input  logic    ar_valid_i,
    input  axi_ax_t ar_i,
    output logic    ar_ready_o,
    output logic    r_valid_o,
    output axi_r_t  r_o,
    input  logic    r_ready_i,
    input  logic    aw_valid_i,
    input  axi_ax_t aw_i,
    output logic    aw_ready_o,
    input  logic    w_valid_i,
    input  axi_w_t  w_i,
    output logic    w_ready_o,
    output logic    b_valid_o,
    output axi_b_t  b_o,
    input  logic    b_ready_i,
    output logic    stuck_o
);

    logic [`BUS_DATA_W-1:0] mem [0:`MEM_WORDS-1];   // Filled by the testbench

    function automatic logic in_range(input logic [`BUS_ADDR_W-1:0] addr);
        return (addr >> 3) < `MEM_WORDS;
    endfunction

    // Hold the beat until the master's ready, then drop it after the edge
    task automatic wait_ready(input logic is_read);
        int t;
        t = 0;
        while (!(is_read ? r_ready_i : b_ready_i) && t < 200) begin
            @(negedge clock);
            t++;
        end
        if (t == 200) begin
            stuck_o = 1'b1;
        end
        @(negedge clock);
    endtask

    task automatic serve_read();
        axi_ax_t ar;
        ar = ar_i;
        repeat ($urandom_range(3)) @(negedge clock);
        ar_ready_o = 1'b1;
        @(negedge clock);
        ar_ready_o = 1'b0;
        repeat ($urandom_range(3)) @(negedge clock);
        r_o = '{id: ar.id, data: '0, resp: SLVERR, last: 1'b1};
        if (in_range(ar.addr)) begin
            r_o.data = mem[ar.addr[`BUS_ADDR_W-1:3]];
            r_o.resp = OKAY;
        end
        r_valid_o = 1'b1;
        wait_ready(1'b1);
        r_valid_o = 1'b0;
    endtask

    task automatic serve_write();
        int unsigned aw_wait;
        int unsigned w_wait;
        int unsigned n;
        logic aw_taken;
        logic w_taken;
        axi_ax_t aw;
        axi_w_t w;
        aw = aw_i;
        w = '0;
        aw_wait = $urandom_range(3);
        w_wait = $urandom_range(3);
        aw_taken = 1'b0;
        w_taken = 1'b0;
        n = 0;
        while (!(aw_taken && w_taken) && n < 200) begin  // AW and W ready on their own delays
            aw_ready_o = !aw_taken && aw_valid_i && n >= aw_wait;
            w_ready_o = !w_taken && w_valid_i && n >= w_wait;
            if (w_ready_o) begin
                w = w_i;
            end
            @(negedge clock);
            aw_taken = aw_taken || aw_ready_o;
            w_taken = w_taken || w_ready_o;
            n++;
        end
        if (!(aw_taken && w_taken)) begin
            stuck_o = 1'b1;
        end
        aw_ready_o = 1'b0;
        w_ready_o = 1'b0;
        b_o = '{id: aw.id, resp: SLVERR};
        if (in_range(aw.addr)) begin
            for (int i = 0; i < `BUS_DATA_W/8; i++) begin
                if (w.strb[i]) begin
                    mem[aw.addr[`BUS_ADDR_W-1:3]][8*i +: 8] = w.data[8*i +: 8];
                end
            end
            b_o.resp = OKAY;
        end
        repeat ($urandom_range(3)) @(negedge clock);
        b_valid_o = 1'b1;
        wait_ready(1'b0);
        b_valid_o = 1'b0;
    endtask

    initial begin
        ar_ready_o = 1'b0;
        r_valid_o = 1'b0;
        r_o = '0;
        aw_ready_o = 1'b0;
        w_ready_o = 1'b0;
        b_valid_o = 1'b0;
        b_o = '0;
        stuck_o = 1'b0;
        forever begin
            @(negedge clock);
            if (ar_valid_i) begin
                serve_read();
            end else if (aw_valid_i) begin
                serve_write();
            end
        end
    end

endmodule

// File: tb/tb_sim_top.sv
`include "bus_cfg.svh"

module tb_sim_top
    import axi_pkg::*, mem_req_pkg::*;
();

    localparam int MEM_BYTES = `MEM_WORDS * 8;
    localparam int WAIT_LIMIT = 200;

    logic        clock = 1'b0;
    logic        rst_n;
    logic        fetch_req;
    logic [31:0] fetch_addr;
    logic        fetch_done;
    logic [31:0] fetch_instr;
    axi_resp_e   fetch_resp;
    logic        ls_req;
    mem_op_e     ls_op;
    logic [31:0] ls_addr;
    mem_size_e   ls_size;
    logic [63:0] ls_wdata;
    logic        ls_done;
    logic [63:0] ls_rdata;
    axi_resp_e   ls_resp;
    logic        ar_valid, ar_ready, r_valid, r_ready, aw_valid, aw_ready;
    logic        w_valid, w_ready, b_valid, b_ready, slave_stuck;
    axi_ax_t     ar, aw;
    axi_w_t      w;
    axi_r_t      r;
    axi_b_t      b;

    logic [7:0]  ref_mem [0:MEM_BYTES-1];    // Byte model of the slave
    int          n_checks;
    int          n_fail;
    logic        hung;
    master_e     last_done;
    master_e     done_order[$];

    always #2 clock = ~clock;

    sim_top dut0 (
        .clock, .rst_n_i(rst_n),
        .fetch_req_i(fetch_req), .fetch_addr_i(fetch_addr), .fetch_done_o(fetch_done),
        .fetch_instr_o(fetch_instr), .fetch_resp_o(fetch_resp),
        .ls_req_i(ls_req), .ls_op_i(ls_op), .ls_addr_i(ls_addr), .ls_size_i(ls_size),
        .ls_wdata_i(ls_wdata), .ls_done_o(ls_done), .ls_rdata_o(ls_rdata), .ls_resp_o(ls_resp),
        .ar_valid_o(ar_valid), .ar_o(ar), .ar_ready_i(ar_ready),
        .r_valid_i(r_valid), .r_i(r), .r_ready_o(r_ready),
        .aw_valid_o(aw_valid), .aw_o(aw), .aw_ready_i(aw_ready),
        .w_valid_o(w_valid), .w_o(w), .w_ready_i(w_ready),
        .b_valid_i(b_valid), .b_i(b), .b_ready_o(b_ready)
    );

    axi_mem_model mem0 (
        .clock,
        .ar_valid_i(ar_valid), .ar_i(ar), .ar_ready_o(ar_ready),
        .r_valid_o(r_valid), .r_o(r), .r_ready_i(r_ready),
        .aw_valid_i(aw_valid), .aw_i(aw), .aw_ready_o(aw_ready),
        .w_valid_i(w_valid), .w_i(w), .w_ready_o(w_ready),
        .b_valid_o(b_valid), .b_o(b), .b_ready_i(b_ready),
        .stuck_o(slave_stuck)
    );

    task automatic compare_value(input logic [63:0] got, input logic [63:0] exp,
                                 input string what);
        n_checks++;
        if (got !== exp) begin
            n_fail++;
            $display("Fail at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    function automatic logic in_memory(input logic [31:0] addr);
        return addr < MEM_BYTES;
    endfunction

    // Little endian, zero-extended
    function automatic logic [63:0] model_read(input logic [31:0] addr, input int size);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < (1 << size); i++) begin
            v[8*i +: 8] = ref_mem[addr + i];
        end
        return v;
    endfunction

    function automatic logic [31:0] pick_addr(input int size);
        return $urandom_range(MEM_BYTES - 1) & ~((32'd1 << size) - 32'd1);
    endfunction

    // One INCR beat with the address and size of a waiting port
    function automatic logic ax_matches(input axi_ax_t ax, input logic is_write);
        logic ifu_ok;
        logic lsu_ok;
        ifu_ok = !is_write && fetch_req && ax.id == MST_IFU &&
                 ax.addr == {fetch_addr[31:2], 2'b00} && ax.size == 3'd2;
        lsu_ok = ls_req && (ls_op == OP_WRITE) == is_write && ax.id == MST_LSU &&
                 ax.addr == ls_addr && ax.size == {1'b0, ls_size};
        return ax.len == 8'd0 && ax.burst == INCR && (ifu_ok || lsu_ok);
    endfunction

    always @(negedge clock) begin
        if (rst_n && ar_valid) begin
            compare_value(ax_matches(ar, 1'b0), 1'b1, "AR beat fields");
        end
        if (rst_n && aw_valid) begin
            compare_value(ax_matches(aw, 1'b1), 1'b1, "AW beat fields");
        end
        if (rst_n && w_valid) begin
            compare_value(w.last, 1'b1, "W last");
        end
    end

    task automatic wait_done(input logic is_fetch, output logic seen);
        int t;
        t = 0;
        seen = 1'b0;
        while (!seen && t < WAIT_LIMIT) begin
            @(negedge clock);
            seen = is_fetch ? fetch_done : ls_done;
            t++;
        end
        if (!seen) begin
            $display("%s request never completed", is_fetch ? "Fetch" : "Load/store");
            n_fail++;
            hung = 1'b1;
        end else begin
            done_order.push_back(is_fetch ? MST_IFU : MST_LSU);
            last_done = is_fetch ? MST_IFU : MST_LSU;
        end
    endtask

    task automatic run_fetch(input logic [31:0] addr);
        logic seen;
        @(negedge clock);
        fetch_addr = addr;
        fetch_req = 1'b1;
        wait_done(1'b1, seen);
        if (seen) begin
            compare_value(fetch_resp, in_memory(addr) ? OKAY : SLVERR,
                          $sformatf("fetch resp at %h", addr));
            if (in_memory(addr)) begin
                compare_value(fetch_instr, model_read(addr, 2), $sformatf("fetch at %h", addr));
            end
            @(negedge clock);             // Held through the done edge
            fetch_req = 1'b0;
        end
    endtask

    task automatic run_ls(input mem_op_e op, input logic [31:0] addr, input mem_size_e size,
                          input logic [63:0] wdata);
        logic seen;
        @(negedge clock);
        ls_op = op;
        ls_addr = addr;
        ls_size = size;
        ls_wdata = wdata;
        ls_req = 1'b1;
        wait_done(1'b0, seen);
        if (seen) begin
            compare_value(ls_resp, in_memory(addr) ? OKAY : SLVERR,
                          $sformatf("%s resp at %h", op.name(), addr));
            if (in_memory(addr) && op == OP_READ) begin
                compare_value(ls_rdata, model_read(addr, size),
                              $sformatf("load size %0d at %h", size, addr));
            end else if (in_memory(addr)) begin
                for (int i = 0; i < (1 << size); i++) begin
                    ref_mem[addr + i] = wdata[8*i +: 8];
                end
            end
            @(negedge clock);
            ls_req = 1'b0;
        end
    endtask

    task automatic report_test(input string name, input int fails_at_start);
        $display("Test %s finished with %0d failures", name, n_fail - fails_at_start);
    endtask

    initial begin
        int          fails_at_start;
        logic [31:0] addr;
        logic [31:0] faddr;
        logic [63:0] word;
        mem_size_e   size;
        mem_op_e     op;
        master_e     first;
        void'($urandom(32'hfe57_0590));
        rst_n = 1'b0;
        fetch_req = 1'b0;
        fetch_addr = '0;
        ls_req = 1'b0;
        ls_op = OP_READ;
        ls_addr = '0;
        ls_size = SZ_BYTE;
        ls_wdata = '0;
        n_checks = 0;
        n_fail = 0;
        hung = 1'b0;
        for (int i = 0; i < `MEM_WORDS; i++) begin
            word = {$urandom, $urandom};
            mem0.mem[i] = word;
            for (int j = 0; j < 8; j++) begin
                ref_mem[8*i + j] = word[8*j +: 8];
            end
        end
        repeat (4) @(negedge clock);
        rst_n = 1'b1;
        compare_value({ar_valid, aw_valid, w_valid, r_ready, b_ready, fetch_done, ls_done},
                      '0, "bus idle after reset");

        fails_at_start = n_fail;
        for (int i = 0; i < 20 && !hung; i++) begin
            run_fetch(pick_addr(2));
        end
        report_test("fetch", fails_at_start);

        fails_at_start = n_fail;
        for (int k = 0; k < 3 && !hung; k++) begin
            addr = pick_addr(3);
            for (int s = 0; s < 4; s++) begin
                for (int off = 0; off < 8 && !hung; off += 1 << s) begin
                    run_ls(OP_READ, addr + off, mem_size_e'(s), '0);
                end
            end
        end
        report_test("load sizes", fails_at_start);

        fails_at_start = n_fail;
        for (int i = 0; i < 40 && !hung; i++) begin
            size = mem_size_e'($urandom_range(3));
            addr = pick_addr(size);
            run_ls(OP_WRITE, addr, size, {$urandom, $urandom});
            run_ls(OP_READ, addr & ~32'h7, SZ_DWORD, '0);     // Whole beat back
        end
        report_test("store strobes", fails_at_start);

        fails_at_start = n_fail;
        for (int i = 0; i < 40 && !hung; i++) begin
            size = mem_size_e'($urandom_range(3));
            addr = pick_addr(size);
            faddr = pick_addr(2);
            op = mem_op_e'($urandom_range(1));
            word = {$urandom, $urandom};
            case ($urandom_range(2))
                0: run_fetch(faddr);
                1: run_ls(op, addr, size, word);
                default: begin
                    // Round robin: the port not served last wins
                    first = (last_done == MST_IFU) ? MST_LSU : MST_IFU;
                    done_order.delete();
                    fork
                        run_fetch(faddr);
                        run_ls(op, addr, size, word);
                    join
                    if (!hung) begin
                        compare_value(done_order[0], first, "first done under contention");
                    end
                end
            endcase
        end
        report_test("shared bus", fails_at_start);

        fails_at_start = n_fail;
        for (int i = 0; i < 12 && !hung; i++) begin
            addr = MEM_BYTES + pick_addr(3);
            case (i % 3)
                0: run_fetch(addr);
                1: run_ls(OP_READ, addr, SZ_DWORD, '0);
                default: begin
                    run_ls(OP_WRITE, addr, SZ_DWORD, {$urandom, $urandom});
                    run_ls(OP_READ, addr - MEM_BYTES, SZ_DWORD, '0);   // No aliasing
                end
            endcase
        end
        report_test("error response", fails_at_start);

        if (slave_stuck) begin
            $display("AXI slave waited too long for a ready");
            n_fail++;
        end
        $display("Checks: %0d, failures: %0d", n_checks, n_fail);
        if (n_fail == 0 && !hung) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
